// File: design/ddr_cfg.svh
`ifndef DDR_CFG_SVH
`define DDR_CFG_SVH

// bus and stream widths
`define DDR_DATA_W      64
`define DDR_ADDR_W      32
`define DDR_BEAT_BYTES  8

// fixed burst shape
`define DDR_BURST_LEN   3

// write region wraps after five bursts
`define DDR_WR_BASE     32'h0000_0000
`define DDR_WR_LIMIT    32'h0000_0060

// read bursts always come from here
`define DDR_RD_BASE     32'h7FE0_0000

// up to seven reads waiting
`define DDR_PEND_W      3

`endif

// File: design/ddr_pkg.sv
`include "ddr_cfg.svh"

package ddr_pkg;

    // aw / ar request
    typedef struct packed {
        logic [`DDR_ADDR_W-1:0] addr;
        logic [7:0]             len;
    } axi_addr_t;

    typedef struct packed {
        logic [`DDR_DATA_W-1:0] data;
        logic                   last;
    } axi_w_t;

    typedef struct packed {
        logic [`DDR_DATA_W-1:0] data;
        logic [1:0]             resp;
        logic                   last;
    } axi_r_t;

    typedef struct packed {
        logic [`DDR_DATA_W-1:0] data;
        logic                   last;
    } stream_beat_t;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        WR_ADV
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    // axi len field is beats minus one
    localparam logic [7:0] BURST_LEN_FIELD = 8'(`DDR_BURST_LEN - 1);

    // big endian <-> little endian
    function automatic logic [`DDR_DATA_W-1:0] byte_swap(input logic [`DDR_DATA_W-1:0] d);
        logic [`DDR_DATA_W-1:0] s;
        for (int i = 0; i < `DDR_BEAT_BYTES; i++) begin
            s[8*i +: 8] = d[8*(`DDR_BEAT_BYTES-1-i) +: 8];
        end
        return s;
    endfunction

endpackage

// File: design/ddr_burst_writer.sv
`timescale 1ns/1ps
`include "ddr_cfg.svh"

module ddr_burst_writer (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic [`DDR_DATA_W-1:0] i_in_data,
    input  logic                   i_in_valid,
    output logic                   o_in_ready,
    output ddr_pkg::axi_addr_t     o_aw,
    output logic                   o_aw_valid,
    input  logic                   i_aw_ready,
    output ddr_pkg::axi_w_t        o_w,
    output logic                   o_w_valid,
    input  logic                   i_w_ready,
    input  logic [1:0]             i_b_resp,
    input  logic                   i_b_valid,
    output logic                   o_b_ready,
    output logic                   o_wr_done,
    output logic                   o_wr_resp_err
);
    import ddr_pkg::*;

    localparam int BEAT_W = $clog2(`DDR_BURST_LEN);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`DDR_BURST_LEN - 1);
    localparam logic [`DDR_ADDR_W-1:0] ADDR_STEP =
        `DDR_ADDR_W'(`DDR_BURST_LEN * `DDR_BEAT_BYTES);

    wr_state_t state_q;
    wr_state_t state_d;
    logic [BEAT_W-1:0] beat_q;
    logic [`DDR_ADDR_W-1:0] addr_q;
    logic aw_hs;
    logic w_hs;
    logic b_hs;

    assign aw_hs = o_aw_valid && i_aw_ready;
    assign w_hs  = o_w_valid && i_w_ready;
    assign b_hs  = i_b_valid && o_b_ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: begin
                if (i_in_valid) begin
                    state_d = WR_ADDR;
                end
            end
            WR_ADDR: begin
                if (aw_hs) begin
                    state_d = WR_DATA;
                end
            end
            WR_DATA: begin
                // leave after the last beat is taken
                if (w_hs && o_w.last) begin
                    state_d = WR_RESP;
                end
            end
            WR_RESP: begin
                if (b_hs) begin
                    state_d = WR_ADV;
                end
            end
            WR_ADV: begin
                state_d = WR_IDLE;
            end
            default: begin
                state_d = WR_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= WR_IDLE;
            beat_q  <= '0;
            addr_q  <= `DDR_WR_BASE;
        end else begin
            state_q <= state_d;
            if (aw_hs) begin
                beat_q <= '0;
            end else if (w_hs) begin
                beat_q <= beat_q + BEAT_W'(1);
            end
            // next burst address, wrap at the limit
            if (state_q == WR_ADV) begin
                if (addr_q >= `DDR_WR_LIMIT) begin
                    addr_q <= `DDR_WR_BASE;
                end else begin
                    addr_q <= addr_q + ADDR_STEP;
                end
            end
        end
    end

    // address channel
    assign o_aw_valid = (state_q == WR_ADDR);
    assign o_aw.addr  = addr_q;
    assign o_aw.len   = BURST_LEN_FIELD;

    // data beats pass straight through, slave stalls reach the input
    assign o_w_valid  = (state_q == WR_DATA) && i_in_valid;
    assign o_in_ready = (state_q == WR_DATA) && i_w_ready;
    assign o_w.data   = byte_swap(i_in_data);
    assign o_w.last   = (beat_q == LAST_BEAT);

    // response
    assign o_b_ready     = (state_q == WR_RESP);
    assign o_wr_done     = b_hs;
    assign o_wr_resp_err = b_hs && (i_b_resp != 2'b00);

endmodule

// File: design/ddr_burst_reader.sv
`timescale 1ns/1ps
`include "ddr_cfg.svh"

module ddr_burst_reader (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_wr_done,
    output ddr_pkg::axi_addr_t     o_ar,
    output logic                   o_ar_valid,
    input  logic                   i_ar_ready,
    input  ddr_pkg::axi_r_t        i_r,
    input  logic                   i_r_valid,
    output logic                   o_r_ready,
    output ddr_pkg::stream_beat_t  o_out,
    output logic                   o_out_valid,
    input  logic                   i_out_ready,
    output logic                   o_rd_resp_err
);
    import ddr_pkg::*;

    rd_state_t state_q;
    rd_state_t state_d;
    logic [`DDR_PEND_W-1:0] pend_q;
    logic ar_hs;
    logic r_hs;
    logic burst_end;

    assign ar_hs     = o_ar_valid && i_ar_ready;
    assign r_hs      = i_r_valid && o_r_ready;
    assign burst_end = r_hs && i_r.last;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: begin
                // unserved write completions waiting
                if (pend_q != '0) begin
                    state_d = RD_ADDR;
                end
            end
            RD_ADDR: begin
                if (ar_hs) begin
                    state_d = RD_DATA;
                end
            end
            RD_DATA: begin
                if (burst_end) begin
                    state_d = RD_IDLE;
                end
            end
            default: begin
                state_d = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= RD_IDLE;
            pend_q  <= '0;
        end else begin
            state_q <= state_d;
            // both at once leaves the count alone
            case ({i_wr_done, burst_end})
                2'b10:   pend_q <= pend_q + `DDR_PEND_W'(1);
                2'b01:   pend_q <= pend_q - `DDR_PEND_W'(1);
                default: pend_q <= pend_q;
            endcase
        end
    end

    assign o_ar_valid = (state_q == RD_ADDR);
    assign o_ar.addr  = `DDR_RD_BASE;
    assign o_ar.len   = BURST_LEN_FIELD;

    // output back-pressure goes straight to rready
    assign o_r_ready   = (state_q == RD_DATA) && i_out_ready;
    assign o_out_valid = (state_q == RD_DATA) && i_r_valid;
    assign o_out.data  = byte_swap(i_r.data);
    assign o_out.last  = i_r.last;

    assign o_rd_resp_err = r_hs && (i_r.resp != 2'b00);

endmodule

// File: design/ddr_stream_top.sv
`timescale 1ns/1ps
`include "ddr_cfg.svh"

module ddr_stream_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic [`DDR_DATA_W-1:0] i_in_data,
    input  logic                   i_in_valid,
    output logic                   o_in_ready,
    output ddr_pkg::stream_beat_t  o_out,
    output logic                   o_out_valid,
    input  logic                   i_out_ready,
    output ddr_pkg::axi_addr_t     o_aw,
    output logic                   o_aw_valid,
    input  logic                   i_aw_ready,
    output ddr_pkg::axi_w_t        o_w,
    output logic                   o_w_valid,
    input  logic                   i_w_ready,
    input  logic [1:0]             i_b_resp,
    input  logic                   i_b_valid,
    output logic                   o_b_ready,
    output ddr_pkg::axi_addr_t     o_ar,
    output logic                   o_ar_valid,
    input  logic                   i_ar_ready,
    input  ddr_pkg::axi_r_t        i_r,
    input  logic                   i_r_valid,
    output logic                   o_r_ready,
    output logic                   o_error
);

    logic wr_done;
    logic wr_resp_err;
    logic rd_resp_err;

    ddr_burst_writer ddr_burst_writer_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_in_data     (i_in_data),
        .i_in_valid    (i_in_valid),
        .o_in_ready    (o_in_ready),
        .o_aw          (o_aw),
        .o_aw_valid    (o_aw_valid),
        .i_aw_ready    (i_aw_ready),
        .o_w           (o_w),
        .o_w_valid     (o_w_valid),
        .i_w_ready     (i_w_ready),
        .i_b_resp      (i_b_resp),
        .i_b_valid     (i_b_valid),
        .o_b_ready     (o_b_ready),
        .o_wr_done     (wr_done),
        .o_wr_resp_err (wr_resp_err)
    );

    // one read burst per write response
    ddr_burst_reader ddr_burst_reader_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_wr_done     (wr_done),
        .o_ar          (o_ar),
        .o_ar_valid    (o_ar_valid),
        .i_ar_ready    (i_ar_ready),
        .i_r           (i_r),
        .i_r_valid     (i_r_valid),
        .o_r_ready     (o_r_ready),
        .o_out         (o_out),
        .o_out_valid   (o_out_valid),
        .i_out_ready   (i_out_ready),
        .o_rd_resp_err (rd_resp_err)
    );

    // sticky until reset
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_error <= 1'b0;
        end else if (wr_resp_err || rd_resp_err) begin
            o_error <= 1'b1;
        end
    end

endmodule

// File: tb/ddr_stream_assert.sv
`timescale 1ns/1ps

module ddr_stream_assert (
    input logic               i_clk,
    input logic               i_rst_n,
    input ddr_pkg::axi_addr_t i_aw,
    input logic               i_aw_valid,
    input logic               i_aw_ready,
    input ddr_pkg::axi_w_t    i_w,
    input logic               i_w_valid,
    input logic               i_w_ready,
    input logic [1:0]         i_b_resp,
    input logic               i_b_valid,
    input logic               i_b_ready,
    input ddr_pkg::axi_addr_t i_ar,
    input logic               i_ar_valid,
    input logic               i_ar_ready,
    input ddr_pkg::axi_r_t    i_r,
    input logic               i_r_valid,
    input logic               i_r_ready,
    input logic               i_out_valid
);

    // valid and payload held until the transfer
    aw_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_aw_valid && !i_aw_ready |=> i_aw_valid && $stable(i_aw))
        else $error("aw valid or payload changed before ready");

    w_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_w_valid && !i_w_ready |=> i_w_valid && $stable(i_w))
        else $error("w valid or payload changed before ready");

    b_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_b_valid && !i_b_ready |=> i_b_valid && $stable(i_b_resp))
        else $error("b valid or response changed before ready");

    ar_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ar_valid && !i_ar_ready |=> i_ar_valid && $stable(i_ar))
        else $error("ar valid or payload changed before ready");

    r_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_r_valid && !i_r_ready |=> i_r_valid && $stable(i_r))
        else $error("r valid or payload changed before ready");

    out_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !i_out_valid)
        else $error("output valid high during reset");

endmodule

bind ddr_stream_top ddr_stream_assert ddr_stream_assert_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_aw        (o_aw),
    .i_aw_valid  (o_aw_valid),
    .i_aw_ready  (i_aw_ready),
    .i_w         (o_w),
    .i_w_valid   (o_w_valid),
    .i_w_ready   (i_w_ready),
    .i_b_resp    (i_b_resp),
    .i_b_valid   (i_b_valid),
    .i_b_ready   (o_b_ready),
    .i_ar        (o_ar),
    .i_ar_valid  (o_ar_valid),
    .i_ar_ready  (i_ar_ready),
    .i_r         (i_r),
    .i_r_valid   (i_r_valid),
    .i_r_ready   (o_r_ready),
    .i_out_valid (o_out_valid)
);

// File: tb/tb_ddr_stream.sv
`timescale 1ns/1ps
`include "ddr_cfg.svh"

module tb_ddr_stream;
    import ddr_pkg::*;

    localparam int N_BURSTS   = 40;
    localparam int N_WORDS    = N_BURSTS * `DDR_BURST_LEN;
    localparam int MAX_CYCLES = N_BURSTS * 60;
    localparam int LAST       = `DDR_BURST_LEN - 1;

    logic i_clk, i_rst_n, i_in_valid, o_in_ready, o_out_valid, i_out_ready;
    logic o_aw_valid, i_aw_ready, o_w_valid, i_w_ready, i_b_valid, o_b_ready;
    logic o_ar_valid, i_ar_ready, i_r_valid, o_r_ready, o_error;
    logic [`DDR_DATA_W-1:0] i_in_data;
    logic [1:0] i_b_resp;
    stream_beat_t o_out;
    axi_addr_t o_aw, o_ar;
    axi_w_t o_w;
    axi_r_t i_r;

    // slave memory as written by the DUT and as the model expects it
    logic [63:0] mem [logic [31:0]];
    logic [63:0] exp_mem [logic [31:0]];
    logic [63:0] in_words [$];
    logic [31:0] lfsr, exp_addr, aw_addr, burst_addr;
    logic exp_error, in_taken, b_taken, r_taken;
    int errors, cycle, words_sent, w_beat, r_beat, out_hold;
    int b_count, ar_count, out_bursts, to_ack, ar_pending, b_delay, r_delay;

    ddr_stream_top ddr_stream_top_i (.*);

    always #5 i_clk = ~i_clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // reverse byte order of a 64-bit word
    function automatic logic [63:0] swap_bytes(input logic [63:0] w);
        logic [63:0] r;
        r = {<<8{w}};
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // everything here transfers at the coming rising edge
    task automatic sample_cycle();
        logic [63:0] word;
        logic w_taken;
        check_value("o_error", 64'(exp_error), 64'(o_error));
        in_taken = i_in_valid && o_in_ready;
        w_taken  = o_w_valid && i_w_ready;
        b_taken  = i_b_valid && o_b_ready;
        r_taken  = i_r_valid && o_r_ready;
        check_value("o_in_ready handshake", 64'(w_taken), 64'(in_taken));
        check_value("o_out_valid handshake", 64'(r_taken), 64'(o_out_valid && i_out_ready));
        if (!i_out_ready) begin
            check_value("o_r_ready", 64'd0, 64'(o_r_ready));
        end
        if (o_aw_valid && i_aw_ready) begin
            check_value("o_aw.addr", 64'(exp_addr), 64'(o_aw.addr));
            check_value("o_aw.len", 64'(LAST), 64'(o_aw.len));
            aw_addr    = o_aw.addr;
            burst_addr = exp_addr;
            if (exp_addr >= `DDR_WR_LIMIT) begin
                exp_addr = `DDR_WR_BASE;
            end else begin
                exp_addr = exp_addr + 32'(`DDR_BURST_LEN * `DDR_BEAT_BYTES);
            end
        end
        if (w_taken) begin
            if (in_words.size() == 0) begin
                report_error("write beat taken with no input word outstanding");
            end else begin
                word = swap_bytes(in_words.pop_front());
                check_value("o_w.data", word, o_w.data);
                check_value("o_w.last", 64'(w_beat == LAST), 64'(o_w.last));
                mem[aw_addr + 32'(w_beat * `DDR_BEAT_BYTES)] = o_w.data;
                exp_mem[burst_addr + 32'(w_beat * `DDR_BEAT_BYTES)] = word;
            end
            w_beat = (w_beat == LAST) ? 0 : w_beat + 1;
            if (w_beat == 0) begin
                to_ack++;
            end
        end
        if (b_taken) begin
            if (i_b_resp != 2'b00) begin
                exp_error = 1'b1;
            end
            b_count++;
            to_ack--;
        end
        if (o_ar_valid && i_ar_ready) begin
            check_value("o_ar.addr", 64'(`DDR_RD_BASE), 64'(o_ar.addr));
            check_value("o_ar.len", 64'(LAST), 64'(o_ar.len));
            ar_count++;
            ar_pending++;
            if (ar_count > b_count) begin
                report_error("read burst requested before its write response");
            end
        end
        if (r_taken) begin
            word = mem[`DDR_RD_BASE + 32'(r_beat * `DDR_BEAT_BYTES)];
            check_value("o_out.data", swap_bytes(word), o_out.data);
            check_value("o_out.last", 64'(r_beat == LAST), 64'(o_out.last));
            if (r_beat == LAST) begin
                r_beat = 0;
                ar_pending--;
                out_bursts++;
            end else begin
                r_beat++;
            end
        end
    endtask

    task automatic drive_cycle();
        if (in_taken || !i_in_valid) begin
            i_in_valid = 1'b0;
            if (words_sent < N_WORDS && rand_bits(2) != 64'd0) begin
                i_in_data  = rand_bits(64);
                i_in_valid = 1'b1;
                in_words.push_back(i_in_data);
                words_sent++;
            end
        end
        i_aw_ready = rand_bits(2) != 64'd0;
        i_w_ready  = rand_bits(2) != 64'd0;
        i_ar_ready = rand_bits(2) != 64'd0;
        // output stalls come in short stretches
        if (out_hold > 0) begin
            out_hold--;
            i_out_ready = 1'b0;
        end else if (rand_bits(3) == 64'd0) begin
            out_hold    = 2 + int'(rand_bits(2));
            i_out_ready = 1'b0;
        end else begin
            i_out_ready = 1'b1;
        end
        if (b_taken) begin
            i_b_valid = 1'b0;
        end
        if (!i_b_valid && to_ack > 0) begin
            if (b_delay > 0) begin
                b_delay--;
            end else begin
                // slverr on the third burst only
                i_b_resp  = (b_count == 2) ? 2'b10 : 2'b00;
                i_b_valid = 1'b1;
                b_delay   = int'(rand_bits(2));
            end
        end
        if (r_taken) begin
            i_r_valid = 1'b0;
        end
        if (!i_r_valid && ar_pending > 0) begin
            if (r_delay > 0) begin
                r_delay--;
            end else begin
                i_r.data  = mem[`DDR_RD_BASE + 32'(r_beat * `DDR_BEAT_BYTES)];
                i_r.resp  = 2'b00;
                i_r.last  = (r_beat == LAST);
                i_r_valid = 1'b1;
                r_delay   = int'(rand_bits(1));
            end
        end
    endtask

    initial begin
        i_clk       = 1'b0;
        i_rst_n     = 1'b0;
        i_in_data   = '0;
        // input valid, w ready and r valid held high while in reset
        i_in_valid  = 1'b1;
        i_out_ready = 1'b0;
        i_aw_ready  = 1'b0;
        i_w_ready   = 1'b1;
        i_b_resp    = 2'b00;
        i_b_valid   = 1'b0;
        i_ar_ready  = 1'b0;
        i_r         = '0;
        i_r_valid   = 1'b1;
        lfsr        = 32'h3bbc_9942;
        exp_addr    = `DDR_WR_BASE;
        aw_addr     = '0;
        burst_addr  = '0;
        exp_error   = 1'b0;
        in_taken    = 1'b0;
        b_taken     = 1'b0;
        r_taken     = 1'b0;
        for (int i = 0; i < `DDR_BURST_LEN; i++) begin
            mem[`DDR_RD_BASE + 32'(i * `DDR_BEAT_BYTES)] = rand_bits(64);
        end

        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        check_value("reset {aw_valid,w_valid,ar_valid,out_valid,b_ready,in_ready,error}",
            64'd0, 64'({o_aw_valid, o_w_valid, o_ar_valid, o_out_valid,
                        o_b_ready, o_in_ready, o_error}));
        @(posedge i_clk);
        #1;
        i_rst_n    = 1'b1;
        i_in_valid = 1'b0;
        i_r_valid  = 1'b0;
        drive_cycle();

        while (cycle < MAX_CYCLES && !(b_count == N_BURSTS && out_bursts == N_BURSTS)) begin
            @(negedge i_clk);
            sample_cycle();
            @(posedge i_clk);
            #1;
            drive_cycle();
            cycle++;
        end

        if (cycle >= MAX_CYCLES) begin
            report_error("run hit the cycle limit before all bursts finished");
        end
        check_value("ar request count", 64'(b_count), 64'(ar_count));
        check_value("output burst count", 64'(b_count), 64'(out_bursts));
        check_value("input words left over", 64'd0, 64'(in_words.size()));
        foreach (exp_mem[addr]) begin
            if (!mem.exists(addr)) begin
                report_error($sformatf("nothing written at address %h", addr));
            end else begin
                check_value($sformatf("mem[%h]", addr), exp_mem[addr], mem[addr]);
            end
        end

        $display("%0d errors, %0d write bursts, %0d read bursts", errors, b_count, out_bursts);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+design
design/ddr_pkg.sv
design/ddr_burst_writer.sv
design/ddr_burst_reader.sv
design/ddr_stream_top.sv
tb/ddr_stream_assert.sv
tb/tb_ddr_stream.sv

// File: run.sh
#!/bin/sh
# build and run the DDR stream testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ddr_stream -f sim.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
